/* source/octree_pkg.sv */
package octree_pkg;

  //////////////////////////////
  // tree geometry and hashing
  //////////////////////////////

  localparam int TREE_LEVEL = 4;
  localparam int LEVEL_W    = $clog2(TREE_LEVEL);
  localparam int POS_WIDTH  = LEVEL_W + 3 * TREE_LEVEL;
  localparam int HASH_WIDTH = 11;
  localparam int HASH_BIAS  = 72;

  // first node index of each level
  localparam logic [9:0] LEVEL_BASE [TREE_LEVEL] = '{10'd0, 10'd1, 10'd9, 10'd73};

  localparam logic [31:0] PRIMES [TREE_LEVEL] = '{
    32'd2099719, 32'd3867465, 32'd807545, 32'd2654435
  };

  // offset 0 is nearest the root
  typedef struct packed {
    logic [LEVEL_W-1:0]             level;
    logic [TREE_LEVEL-1:0][2:0]     offsets;
  } pos_t;

  // slot 0 sits in the low bits
  typedef struct packed {
    pos_t            pos;
    logic [7:0][2:0] slots;
    logic [3:0]      count;
  } pos_list_t;

  // bit 2k is the child flag, bit 2k+1 the anchor flag of child k
  typedef struct packed {
    logic anchor;
    logic child;
  } rec_pair_t;

  typedef struct packed {
    rec_pair_t [7:0] pair;
  } node_rec_t;

  // tree words and feature words share the memory
  typedef union packed {
    node_rec_t [3:0] nodes;
    logic [63:0]     feature;
  } mem_word_u;

  typedef struct packed {
    logic        cen;
    logic [31:0] addr;
  } mem_req_t;

  // level field holds the parent level, anchor depth is level + 1
  function automatic logic [HASH_WIDTH-1:0] anchor_hash(pos_t p);
    logic [31:0] acc;
    acc = '0;
    case (p.level)
      2'd0: acc = 32'(p.offsets[0]) + 32'd1;
      2'd1: acc = (32'(p.offsets[0]) + 32'd1) + 32'd8 * (32'(p.offsets[1]) + 32'd1);
      default: begin
        for (int i = 0; i < TREE_LEVEL; i++) begin
          if (i <= int'(p.level)) begin
            acc = acc ^ ((32'(p.offsets[i]) + 32'd1) * PRIMES[i]);
          end
        end
        acc = acc + 32'(HASH_BIAS);
      end
    endcase
    return acc[HASH_WIDTH-1:0];
  endfunction

endpackage

/* source/anchor_fifo.sv */
`timescale 1ns/1ps

module anchor_fifo #(
  parameter int DEPTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  octree_pkg::pos_list_t din,
  input  logic                  pop,
  output octree_pkg::pos_list_t dout,
  output logic                  empty,
  output logic                  full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  octree_pkg::pos_list_t mem [DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [CW-1:0]         count;
  logic                  do_push;
  logic                  do_pop;

  assign empty   = (count == '0);
  assign full    = (count == CW'(DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
      end
      count <= count + CW'(do_push) - CW'(do_pop);
    end
  end

  // read data lands one cycle after pop
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
    if (do_pop) begin
      dout <= mem[rd_ptr];
    end
  end

endmodule

/* source/node_fetch.sv */
`timescale 1ns/1ps

module node_fetch #(
  parameter int TREE_BASE = 0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  q_empty,
  output logic                  q_pop,
  input  octree_pkg::pos_list_t q_data,
  output octree_pkg::mem_req_t  mem,
  output octree_pkg::pos_t      tag_pos,
  output logic [1:0]            tag_lane,
  output logic                  tag_valid,
  output logic                  busy
);

  localparam logic [1:0] S_POP   = 2'd0;
  localparam logic [1:0] S_ISSUE = 2'd1;
  localparam logic [1:0] S_GAP   = 2'd2;

  logic [1:0]       state;
  logic [2:0]       slot_idx;
  octree_pkg::pos_t child_pos;
  logic [9:0]       child_index;
  octree_pkg::pos_t iss_pos;
  logic [1:0]       iss_lane;

  // level base plus offsets as a base-8 number
  function automatic logic [9:0] node_index(octree_pkg::pos_t p);
    logic [9:0] idx;
    idx = '0;
    for (int i = 0; i < octree_pkg::TREE_LEVEL; i++) begin
      if (i < int'(p.level)) begin
        idx = {idx[6:0], p.offsets[i]};
      end
    end
    return idx + octree_pkg::LEVEL_BASE[p.level];
  endfunction

  always_comb begin
    child_pos                           = q_data.pos;
    child_pos.level                     = q_data.pos.level + 2'd1;
    child_pos.offsets[q_data.pos.level] = q_data.slots[slot_idx];
    child_index                         = node_index(child_pos);
  end

  assign q_pop = (state == S_POP) && !q_empty;
  assign busy  = (state != S_POP) || !mem.cen;

  // reads go out every other cycle, which leaves mask_decode a spare push slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_POP;
      slot_idx <= '0;
    end else begin
      case (state)
        S_POP: begin
          slot_idx <= '0;
          if (!q_empty) begin
            state <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          if ({1'b0, slot_idx} == q_data.count - 4'd1) begin
            state <= S_POP;
          end else begin
            state    <= S_GAP;
            slot_idx <= slot_idx + 3'd1;
          end
        end
        S_GAP: state <= S_ISSUE;
        default: state <= S_POP;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem       <= '{cen: 1'b1, addr: '0};
      tag_valid <= 1'b0;
    end else begin
      tag_valid <= !mem.cen;
      if (start) begin
        mem <= '{cen: 1'b0, addr: 32'(TREE_BASE)};
      end else if (state == S_ISSUE) begin
        mem <= '{cen: 1'b0, addr: 32'(TREE_BASE) + 32'(child_index >> 2)};
      end else begin
        mem.cen <= 1'b1;
      end
    end
  end

  // tag follows the read by one cycle to meet the data
  always_ff @(posedge clk) begin
    if (start) begin
      iss_pos  <= '0;
      iss_lane <= '0;
    end else if (state == S_ISSUE) begin
      iss_pos  <= child_pos;
      iss_lane <= child_index[1:0];
    end
    tag_pos  <= iss_pos;
    tag_lane <= iss_lane;
  end

endmodule

/* source/mask_decode.sv */
`timescale 1ns/1ps

module mask_decode (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  octree_pkg::pos_t                      tag_pos,
  input  logic [1:0]                            tag_lane,
  input  logic                                  tag_valid,
  input  octree_pkg::mem_word_u                 rdata,
  input  logic [octree_pkg::TREE_LEVEL-1:0]     lod_active,
  output logic                                  child_push,
  output logic                                  anchor_push,
  output octree_pkg::pos_list_t                 entry,
  output logic                                  busy
);

  octree_pkg::node_rec_t rec;
  octree_pkg::pos_t      rec_pos;
  logic                  rec_valid;
  logic [7:0]            child_mask;
  logic [7:0]            anchor_mask;
  octree_pkg::pos_list_t child_list;
  octree_pkg::pos_list_t anchor_list;
  octree_pkg::pos_list_t hold_list;
  logic                  hold_valid;
  logic                  lod_ok;
  logic                  child_go;
  logic                  anchor_go;

  // set bit indices packed from slot 0 upward
  function automatic octree_pkg::pos_list_t compress(octree_pkg::pos_t pos,
                                                     logic [7:0] mask);
    octree_pkg::pos_list_t l;
    l     = '0;
    l.pos = pos;
    for (int k = 0; k < 8; k++) begin
      if (mask[k]) begin
        l.slots[l.count[2:0]] = 3'(k);
        l.count               = l.count + 4'd1;
      end
    end
    return l;
  endfunction

  always_comb begin
    for (int k = 0; k < 8; k++) begin
      child_mask[k]  = rec.pair[k].child;
      anchor_mask[k] = rec.pair[k].anchor;
    end
    child_list  = compress(rec_pos, child_mask);
    anchor_list = compress(rec_pos, anchor_mask);
  end

  // lod gate on the parent level, leaves never queue children
  assign lod_ok    = lod_active[rec_pos.level];
  assign child_go  = rec_valid && lod_ok && child_list.count != '0 &&
                     (int'(rec_pos.level) < octree_pkg::TREE_LEVEL - 1);
  assign anchor_go = rec_valid && lod_ok && anchor_list.count != '0;

  // records come at most every other cycle, so a held anchor list never collides
  assign child_push  = child_go;
  assign anchor_push = hold_valid || (anchor_go && !child_go);
  assign entry       = child_go ? child_list : (hold_valid ? hold_list : anchor_list);
  assign busy        = tag_valid || rec_valid || hold_valid;

  always_ff @(posedge clk) begin
    if (tag_valid) begin
      rec     <= rdata.nodes[tag_lane];
      rec_pos <= tag_pos;
    end
    if (child_go && anchor_go) begin
      hold_list <= anchor_list;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rec_valid  <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      rec_valid  <= tag_valid;
      hold_valid <= child_go && anchor_go;
    end
  end

endmodule

/* source/feature_fetch.sv */
`timescale 1ns/1ps

module feature_fetch #(
  parameter int FEATURE_LENGTH = 10,
  parameter int FEATURE_BASE   = 1200
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  q_empty,
  output logic                  q_pop,
  input  octree_pkg::pos_list_t q_data,
  output octree_pkg::mem_req_t  mem,
  input  octree_pkg::mem_word_u rdata,
  output logic [63:0]           feature,
  output logic                  feature_valid,
  output logic                  done
);

  localparam int WORD_W = (FEATURE_LENGTH > 1) ? $clog2(FEATURE_LENGTH) : 1;

  localparam logic [1:0] F_IDLE  = 2'd0;
  localparam logic [1:0] F_POP   = 2'd1;
  localparam logic [1:0] F_HASH  = 2'd2;
  localparam logic [1:0] F_ISSUE = 2'd3;

  logic [1:0]                        state;
  logic [2:0]                        slot_idx;
  logic [WORD_W-1:0]                 word_idx;
  logic [octree_pkg::HASH_WIDTH-1:0] hash_q;
  octree_pkg::pos_t                  anchor_pos;
  logic                              last_word;
  logic                              last_slot;

  always_comb begin
    anchor_pos                           = q_data.pos;
    anchor_pos.offsets[q_data.pos.level] = q_data.slots[slot_idx];
  end

  assign last_word = (word_idx == WORD_W'(FEATURE_LENGTH - 1));
  assign last_slot = ({1'b0, slot_idx} == q_data.count - 4'd1);
  assign q_pop     = (state == F_POP) && !q_empty;
  // last word is on the output when the port goes quiet
  assign done      = (state == F_POP) && q_empty && mem.cen;
  assign feature   = feature_valid ? rdata.feature : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= F_IDLE;
      slot_idx <= '0;
      word_idx <= '0;
    end else begin
      case (state)
        F_IDLE: begin
          if (start) begin
            state <= F_POP;
          end
        end
        F_POP: begin
          slot_idx <= '0;
          if (!q_empty) begin
            state <= F_HASH;
          end else if (mem.cen) begin
            state <= F_IDLE;
          end
        end
        F_HASH: begin
          word_idx <= '0;
          state    <= F_ISSUE;
        end
        default: begin
          word_idx <= word_idx + WORD_W'(1);
          if (last_word) begin
            if (last_slot) begin
              state <= F_POP;
            end else begin
              slot_idx <= slot_idx + 3'd1;
              state    <= F_HASH;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == F_HASH) begin
      hash_q <= octree_pkg::anchor_hash(anchor_pos);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem           <= '{cen: 1'b1, addr: '0};
      feature_valid <= 1'b0;
    end else begin
      feature_valid <= !mem.cen;
      mem.cen       <= (state != F_ISSUE);
      mem.addr      <= 32'(FEATURE_BASE) + 32'(hash_q) * 32'(FEATURE_LENGTH) +
                       32'(word_idx);
    end
  end

endmodule

/* source/octree_searcher.sv */
`timescale 1ns/1ps

module octree_searcher #(
  parameter int FEATURE_LENGTH = 10,
  parameter int TREE_BASE      = 0,
  parameter int FEATURE_BASE   = 1200,
  parameter int QUEUE_DEPTH    = 32
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              search_req,
  output logic                              search_ack,
  input  logic [octree_pkg::TREE_LEVEL-1:0] lod_active,
  output octree_pkg::mem_req_t              mem,
  input  octree_pkg::mem_word_u             mem_rdata,
  output logic [63:0]                       feature,
  output logic                              feature_valid
);

  localparam logic [1:0] PH_IDLE   = 2'd0;
  localparam logic [1:0] PH_SEARCH = 2'd1;
  localparam logic [1:0] PH_OUTPUT = 2'd2;
  localparam logic [1:0] PH_ACK    = 2'd3;

  logic [1:0]                        phase;
  logic                              req_q;
  logic [octree_pkg::TREE_LEVEL-1:0] lod_q;
  logic                              accept;
  logic                              search_end;
  logic                              search_pop;
  logic                              search_empty;
  octree_pkg::pos_list_t             search_dout;
  logic                              anchor_pop;
  logic                              anchor_empty;
  octree_pkg::pos_list_t             anchor_dout;
  octree_pkg::mem_req_t              nf_mem;
  octree_pkg::mem_req_t              ff_mem;
  logic                              nf_busy;
  logic                              md_busy;
  octree_pkg::pos_t                  tag_pos;
  logic [1:0]                        tag_lane;
  logic                              tag_valid;
  logic                              child_push;
  logic                              anchor_push;
  octree_pkg::pos_list_t             md_entry;
  logic                              ff_done;

  //////////////////////////////
  // phase control and req/ack
  //////////////////////////////

  assign accept     = (phase == PH_IDLE) && search_req && !req_q && !search_ack;
  // nothing queued, nothing in flight, nothing waiting to push
  assign search_end = (phase == PH_SEARCH) && search_empty && !nf_busy && !md_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase      <= PH_IDLE;
      req_q      <= 1'b0;
      search_ack <= 1'b0;
    end else begin
      req_q <= search_req;
      case (phase)
        PH_IDLE: begin
          if (accept) begin
            phase <= PH_SEARCH;
          end
        end
        PH_SEARCH: begin
          if (search_end) begin
            phase <= PH_OUTPUT;
          end
        end
        PH_OUTPUT: begin
          if (ff_done) begin
            phase      <= PH_ACK;
            search_ack <= 1'b1;
          end
        end
        default: begin
          if (!search_req) begin
            phase      <= PH_IDLE;
            search_ack <= 1'b0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      lod_q <= lod_active;
    end
  end

  // port owner follows the phase
  always_comb begin
    case (phase)
      PH_SEARCH: mem = nf_mem;
      PH_OUTPUT: mem = ff_mem;
      default:   mem = '{cen: 1'b1, addr: '0};
    endcase
  end

  //////////////////////////////
  // queues and stages
  //////////////////////////////

  anchor_fifo #(
    .DEPTH (QUEUE_DEPTH)
  ) u_search_q (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (child_push),
    .din   (md_entry),
    .pop   (search_pop),
    .dout  (search_dout),
    .empty (search_empty),
    .full  ()
  );

  anchor_fifo #(
    .DEPTH (QUEUE_DEPTH)
  ) u_anchor_q (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (anchor_push),
    .din   (md_entry),
    .pop   (anchor_pop),
    .dout  (anchor_dout),
    .empty (anchor_empty),
    .full  ()
  );

  node_fetch #(
    .TREE_BASE (TREE_BASE)
  ) u_node_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (accept),
    .q_empty   (search_empty),
    .q_pop     (search_pop),
    .q_data    (search_dout),
    .mem       (nf_mem),
    .tag_pos   (tag_pos),
    .tag_lane  (tag_lane),
    .tag_valid (tag_valid),
    .busy      (nf_busy)
  );

  mask_decode u_mask_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .tag_pos     (tag_pos),
    .tag_lane    (tag_lane),
    .tag_valid   (tag_valid),
    .rdata       (mem_rdata),
    .lod_active  (lod_q),
    .child_push  (child_push),
    .anchor_push (anchor_push),
    .entry       (md_entry),
    .busy        (md_busy)
  );

  feature_fetch #(
    .FEATURE_LENGTH (FEATURE_LENGTH),
    .FEATURE_BASE   (FEATURE_BASE)
  ) u_feature_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (search_end),
    .q_empty       (anchor_empty),
    .q_pop         (anchor_pop),
    .q_data        (anchor_dout),
    .mem           (ff_mem),
    .rdata         (mem_rdata),
    .feature       (feature),
    .feature_valid (feature_valid),
    .done          (ff_done)
  );

endmodule

/* verification/octree_model.svh */
`ifndef OCTREE_MODEL_SVH
`define OCTREE_MODEL_SVH

localparam int TB_SEED        = 32'h27bf28a4;
localparam int MEM_WORDS      = 32768;
localparam int TIMEOUT_MARGIN = 200;

localparam int NODE_COUNT  = 585;
localparam int TREE_WORDS  = (NODE_COUNT + 3) / 4;
// keeps both queues at or below their depth
localparam int NODE_BUDGET = 24;

localparam int SHAPE_RANDOM = 0;
localparam int SHAPE_FIXED  = 1;
localparam int SHAPE_EMPTY  = 2;
localparam int SHAPE_PREV   = 3;

localparam int         MODEL_LEVEL_BASE [4] = '{0, 1, 9, 73};
localparam int         MODEL_PRIMES     [4] = '{2099719, 3867465, 807545, 2654435};
localparam logic [7:0] FIXED_CHILD      [4] = '{8'h81, 8'h24, 8'h12, 8'h40};

logic [15:0] node_rec [NODE_COUNT];
logic [63:0] exp_words [$];
int          exp_visits;
int          rand_seed;

function automatic int model_index(octree_pkg::pos_t p);
  int idx;
  idx = 0;
  for (int i = 0; i < int'(p.level); i++) begin
    idx = idx * 8 + int'(p.offsets[i]);
  end
  return MODEL_LEVEL_BASE[p.level] + idx;
endfunction

// anchor depth is level + 1
function automatic int model_hash(octree_pkg::pos_t a);
  int h;
  h = 0;
  case (int'(a.level))
    0: h = int'(a.offsets[0]) + 1;
    1: h = int'(a.offsets[0]) + 1 + 8 * (int'(a.offsets[1]) + 1);
    default: begin
      for (int i = 0; i <= int'(a.level); i++) begin
        h = h ^ ((int'(a.offsets[i]) + 1) * MODEL_PRIMES[i]);
      end
      h = h + 72;
    end
  endcase
  return h & 32'h7ff;
endfunction

// upper half tags the whole address, lower half counts from the feature base
function automatic logic [63:0] feature_word(int addr);
  return {32'(addr) ^ 32'h5a3c96e1, 32'hfe000000 + 32'(addr - FEATURE_BASE)};
endfunction

function automatic logic [7:0] random_mask(int density);
  logic [7:0] m;
  for (int k = 0; k < 8; k++) begin
    m[k] = ((($random(rand_seed) & 32'h7fffffff) % 100) < density);
  end
  return m;
endfunction

function automatic void build_tree(int shape, int density);
  octree_pkg::pos_t q [$];
  octree_pkg::pos_t p;
  octree_pkg::pos_t c;
  logic [7:0]       cm;
  logic [7:0]       am;
  int               idx;
  int               nodes;
  if (shape != SHAPE_PREV) begin
    // nodes outside the tree hold junk that must never be read
    for (int n = 0; n < NODE_COUNT; n++) begin
      node_rec[n] = 16'($random(rand_seed));
    end
    q.push_back('0);
    nodes = 1;
    while (q.size() > 0) begin
      p   = q.pop_front();
      idx = model_index(p);
      if (shape == SHAPE_EMPTY) begin
        cm = '0;
        am = '0;
      end else if (shape == SHAPE_FIXED) begin
        cm = FIXED_CHILD[idx % 4];
        am = 8'(idx * 37) ^ 8'h5a;
      end else begin
        cm = random_mask(density);
        am = random_mask(density);
      end
      if (p.level < 3) begin
        for (int k = 0; k < 8; k++) begin
          if (cm[k] && nodes < NODE_BUDGET) begin
            nodes = nodes + 1;
            c                  = p;
            c.level            = p.level + 2'd1;
            c.offsets[p.level] = 3'(k);
            q.push_back(c);
          end else begin
            cm[k] = 1'b0;
          end
        end
      end
      for (int k = 0; k < 8; k++) begin
        node_rec[idx][2*k]   = cm[k];
        node_rec[idx][2*k+1] = am[k];
      end
    end
  end
endfunction

// breadth first walk, gated on each node's own level
function automatic void compute_expected(logic [3:0] lod);
  octree_pkg::pos_t q [$];
  octree_pkg::pos_t p;
  octree_pkg::pos_t a;
  logic [15:0]      r;
  int               base;
  exp_words.delete();
  exp_visits = 0;
  q.push_back('0);
  while (q.size() > 0) begin
    p          = q.pop_front();
    r          = node_rec[model_index(p)];
    exp_visits = exp_visits + 1;
    if (lod[p.level]) begin
      for (int k = 0; k < 8; k++) begin
        if (r[2*k+1]) begin
          a                  = p;
          a.offsets[p.level] = 3'(k);
          base = FEATURE_BASE + model_hash(a) * FEATURE_LENGTH;
          for (int j = 0; j < FEATURE_LENGTH; j++) begin
            exp_words.push_back(feature_word(base + j));
          end
        end
      end
      if (p.level < 3) begin
        for (int k = 0; k < 8; k++) begin
          if (r[2*k]) begin
            a                  = p;
            a.level            = p.level + 2'd1;
            a.offsets[p.level] = 3'(k);
            q.push_back(a);
          end
        end
      end
    end
  end
endfunction

`endif

/* verification/octree_searcher_tb.sv */
`timescale 1ns/1ps

module octree_searcher_tb;

  localparam int FEATURE_LENGTH = 10;
  localparam int TREE_BASE      = 0;
  localparam int FEATURE_BASE   = 1200;
  localparam int QUEUE_DEPTH    = 32;
  localparam int NUM_ROWS       = 7;

  `include "octree_model.svh"

  typedef struct packed {
    logic [1:0]  shape;
    logic [7:0]  density;
    logic [3:0]  lod;
    logic [15:0] exp_count;
  } stim_row_t;

  logic                  clk;
  logic                  rst_n;
  logic                  search_req;
  logic                  search_ack;
  logic [3:0]            lod_active;
  octree_pkg::mem_req_t  mem;
  octree_pkg::mem_req_t  pend;
  octree_pkg::mem_word_u mem_rdata;
  logic [63:0]           feature;
  logic                  feature_valid;

  stim_row_t   rows [NUM_ROWS];
  string       row_names [NUM_ROWS];
  logic [63:0] got_words [$];
  logic [63:0] prev_words [$];
  int          node_reads;
  int          cycle_count;
  int          cycle_limit;

  octree_searcher #(
    .FEATURE_LENGTH (FEATURE_LENGTH),
    .TREE_BASE      (TREE_BASE),
    .FEATURE_BASE   (FEATURE_BASE),
    .QUEUE_DEPTH    (QUEUE_DEPTH)
  ) u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .search_req    (search_req),
    .search_ack    (search_ack),
    .lod_active    (lod_active),
    .mem           (mem),
    .mem_rdata     (mem_rdata),
    .feature       (feature),
    .feature_valid (feature_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // memory model and monitor
  //////////////////////////////

  function automatic logic [63:0] memory_word(int addr);
    logic [63:0] w;
    int          n;
    w = '0;
    if (addr >= TREE_BASE && addr < TREE_BASE + TREE_WORDS) begin
      for (int lane = 0; lane < 4; lane++) begin
        n = 4 * (addr - TREE_BASE) + lane;
        if (n < NODE_COUNT) begin
          w[16*lane +: 16] = node_rec[n];
        end
      end
    end else begin
      w = feature_word(addr);
    end
    return w;
  endfunction

  // request seen at one falling edge is answered at the next
  always @(negedge clk) begin
    if (!pend.cen) begin
      if (pend.addr >= MEM_WORDS) begin
        $display("[ERROR] the DUT read address %0d, outside the memory", pend.addr);
        abort_run();
      end else begin
        mem_rdata <= memory_word(int'(pend.addr));
        if (int'(pend.addr) >= TREE_BASE && int'(pend.addr) < TREE_BASE + TREE_WORDS) begin
          node_reads = node_reads + 1;
        end
      end
    end
    pend <= mem;
  end

  always @(posedge clk) begin
    if (rst_n && feature_valid === 1'b1) begin
      got_words.push_back(feature);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("[ERROR] timeout, the run did not end within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "stopping on the first error");
  endtask

  task automatic check_feature(string test, int index, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s word %0d expected %h actual %h", test, index, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(string test, string what, int exp, int act);
    if (exp !== act) begin
      $display("[ERROR] %s %s expected %0d actual %0d", test, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_ack(string test, logic exp, logic act);
    if (exp !== act) begin
      $display("[ERROR] %s search_ack expected %b actual %b", test, exp, act);
      abort_run();
    end
  endtask

  task automatic check_valid(string test, logic exp, logic act);
    if (exp !== act) begin
      $display("[ERROR] %s feature_valid expected %b actual %b", test, exp, act);
      abort_run();
    end
  endtask

  task automatic check_port(string test, octree_pkg::mem_req_t exp, octree_pkg::mem_req_t act);
    if (exp !== act) begin
      $display("[ERROR] %s mem expected %h actual %h", test, exp, act);
      abort_run();
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // exp_count of ffff means the word count comes from the model only
  task automatic load_table();
    row_names[0] = "full_lod_random";
    rows[0]      = '{SHAPE_RANDOM, 8'd40, 4'b1111, 16'hffff};
    row_names[1] = "lod_gate_level1";
    rows[1]      = '{SHAPE_RANDOM, 8'd45, 4'b1101, 16'hffff};
    row_names[2] = "lod_gate_level3";
    rows[2]      = '{SHAPE_RANDOM, 8'd40, 4'b0111, 16'hffff};
    row_names[3] = "empty_root";
    rows[3]      = '{SHAPE_EMPTY, 8'd0, 4'b1111, 16'd0};
    row_names[4] = "root_gated";
    rows[4]      = '{SHAPE_RANDOM, 8'd50, 4'b1110, 16'd0};
    row_names[5] = "fixed_pattern";
    rows[5]      = '{SHAPE_FIXED, 8'd0, 4'b1111, 16'hffff};
    row_names[6] = "rerun_fixed";
    rows[6]      = '{SHAPE_PREV, 8'd0, 4'b1111, 16'hffff};
  endtask

  task automatic run_row(int r);
    string name;
    name = row_names[r];
    build_tree(int'(rows[r].shape), int'(rows[r].density));
    compute_expected(rows[r].lod);
    got_words.delete();
    node_reads = 0;
    @(negedge clk);
    lod_active = rows[r].lod;
    search_req = 1'b1;
    while (search_ack !== 1'b1) begin
      @(posedge clk);
    end
    // ack must hold while req stays high
    repeat (3) begin
      @(posedge clk);
      check_ack(name, 1'b1, search_ack);
    end
    @(negedge clk);
    search_req = 1'b0;
    repeat (2) @(posedge clk);
    check_ack(name, 1'b0, search_ack);
    // subtrees under gated parents are never read
    check_count(name, "node reads", exp_visits, node_reads);
    if (rows[r].exp_count != 16'hffff) begin
      check_count(name, "table word count", int'(rows[r].exp_count), got_words.size());
    end
    if (rows[r].shape == 2'(SHAPE_PREV)) begin
      check_count(name, "rerun word count", prev_words.size(), got_words.size());
      for (int i = 0; i < prev_words.size(); i++) begin
        check_feature(name, i, prev_words[i], got_words[i]);
      end
    end
    check_count(name, "word count", exp_words.size(), got_words.size());
    for (int i = 0; i < exp_words.size(); i++) begin
      check_feature(name, i, exp_words[i], got_words[i]);
    end
    prev_words = got_words;
  endtask

  initial begin
    octree_pkg::mem_req_t idle_req;
    rst_n       = 1'b0;
    search_req  = 1'b0;
    lod_active  = '0;
    mem_rdata   = '0;
    pend        = '{cen: 1'b1, addr: '0};
    node_reads  = 0;
    cycle_count = 0;
    idle_req    = '{cen: 1'b1, addr: '0};
    load_table();

    // dry pass over the table to size the timeout
    rand_seed   = TB_SEED;
    cycle_limit = 5 + TIMEOUT_MARGIN;
    for (int r = 0; r < NUM_ROWS; r++) begin
      build_tree(int'(rows[r].shape), int'(rows[r].density));
      compute_expected(rows[r].lod);
      cycle_limit = cycle_limit + exp_visits * 8 + exp_words.size() * 2 + 40;
    end
    rand_seed = TB_SEED;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_ack("reset", 1'b0, search_ack);
    check_valid("reset", 1'b0, feature_valid);
    check_port("reset", idle_req, mem);

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

/* octree_searcher.f */
+incdir+verification
source/octree_pkg.sv
source/anchor_fifo.sv
source/node_fetch.sv
source/mask_decode.sv
source/feature_fetch.sv
source/octree_searcher.sv
verification/octree_searcher_tb.sv

/* Bender.yml */
package:
  name: octree_searcher

sources:
  - files:
      - source/octree_pkg.sv
      - source/anchor_fifo.sv
      - source/node_fetch.sv
      - source/mask_decode.sv
      - source/feature_fetch.sv
      - source/octree_searcher.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/octree_searcher_tb.sv
